// File: verilog.f
hdl/spine_pkg.sv
hdl/pcReg.sv
hdl/stageReg.sv
hdl/commitReg.sv
hdl/hazardUnit.sv
hdl/pipeSpine.sv
verification/clockGen.sv
verification/pipeSpineTb.sv

// File: run.sh
#!/bin/sh
# Build and run the pipeline spine testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert -j 0 \
    -f verilog.f \
    --top-module pipeSpineTb \
    -Mdir "$BUILD" \
    -o pipeSpineTb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$BUILD/pipeSpineTb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
    echo "simulation reported errors, see $LOG"
    exit 1
fi

if ! grep -q "Done: no errors" "$LOG"; then
    echo "simulation ended without a result line, see $LOG"
    exit 1
fi

echo "simulation passed"
exit 0

// File: verification/spine_cases.txt
// columns: fetchWait renameFull issueFull execBusy redirect redirectPc stallMask
// stallMask holds the expected stall levels, msb first: F D R I E
0 0 0 0 0 00000000 00
0 0 0 0 0 00000000 00
0 0 0 0 0 00000000 00
0 0 1 0 0 00000000 1e
0 0 1 0 0 00000000 1e
0 0 0 0 0 00000000 00
1 0 0 0 0 00000000 10
1 0 0 0 0 00000000 10
0 0 0 0 0 00000000 00
0 1 0 0 0 00000000 1c
0 0 0 0 0 00000000 00
0 0 0 1 0 00000000 1f
0 0 0 1 0 00000000 1f
0 0 0 0 1 9fc01000 00
0 0 0 0 0 00000000 00
0 0 1 0 1 80000040 1e
0 0 0 0 0 00000000 00
0 0 0 1 1 bfc00100 1f
0 0 0 0 0 00000000 00
1 1 1 1 0 00000000 1f
0 0 0 0 0 00000000 00
0 0 0 0 0 00000000 00

// File: verification/pipeSpineTb.sv
`timescale 1ns/1ps

module pipeSpineTb;
    import spine_pkg::*;

    localparam int NUM_CASES   = 22;
    localparam int CASE_COLS   = 7;
    localparam int CYCLE_LIMIT = NUM_CASES + 40;
    localparam int SEED        = 75133;

    localparam int FW = FETCH_W * MACHINE_WIDTH;
    localparam int DW = DECODE_W * MACHINE_WIDTH;
    localparam int RW = RENAME_W * MACHINE_WIDTH;
    localparam int CW = UNIT_NUM * COMMIT_LANE_W;

    logic          clk;
    logic          resetn;
    logic          fetchWait;
    logic          renameFull;
    logic          issueFull;
    logic          execBusy;
    logic          redirect;
    logic [31:0]   redirectPc;
    logic [31:0]   pcNext;
    logic [FW-1:0] fetchIn;
    logic [DW-1:0] decodeIn;
    logic [RW-1:0] renameIn;
    logic [ISSUE_W-1:0] issueIn;
    logic [CW-1:0] execIn;

    logic [31:0]   pc;
    logic [FW-1:0] fetchOut;
    logic [DW-1:0] decodeOut;
    logic [RW-1:0] renameOut;
    logic [ISSUE_W-1:0] issueOut;
    logic [CW-1:0] commitOut;

    logic [31:0] caseMem [0:NUM_CASES*CASE_COLS-1];
    logic [4:0]  caseStall;         // expected F D R I E stalls of the applied case

    // shadow copies of every register
    logic [31:0]   mPc;
    logic [FW-1:0] mFetch;
    logic [DW-1:0] mDecode;
    logic [RW-1:0] mRename;
    logic [ISSUE_W-1:0] mIssue;
    logic [CW-1:0] mCommit;
    logic [CW-1:0] ctrlMask;        // valid and robAddr bits of all lanes

    int          errorCount;
    int          cycleCount = 0;

    clockGen clockGen_i (
        .clk    (clk),
        .resetn (resetn)
    );

    pipeSpine dut_i (
        .clk        (clk),
        .resetn     (resetn),
        .fetchWait  (fetchWait),
        .renameFull (renameFull),
        .issueFull  (issueFull),
        .execBusy   (execBusy),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .pcNext     (pcNext),
        .fetchIn    (fetchIn),
        .decodeIn   (decodeIn),
        .renameIn   (renameIn),
        .issueIn    (issueIn),
        .execIn     (execIn),
        .pc         (pc),
        .fetchOut   (fetchOut),
        .decodeOut  (decodeOut),
        .renameOut  (renameOut),
        .issueOut   (issueOut),
        .commitOut  (commitOut)
    );

    task automatic flagWrong(input string name, input logic [255:0] expected,
                             input logic [255:0] actual);
        errorCount++;
        $display("ERROR t=%0t %s expected %h actual %h", $time, name, expected, actual);
    endtask

    function automatic logic [255:0] randomBits();
        logic [255:0] r;
        for (int k = 0; k < 8; k++) begin
            r[k*32 +: 32] = $urandom;
        end
        return r;
    endfunction

    task automatic applyCase(input int idx);
        logic [255:0] r;
        int base;
        base = idx * CASE_COLS;
        fetchWait  <= caseMem[base][0];
        renameFull <= caseMem[base+1][0];
        issueFull  <= caseMem[base+2][0];
        execBusy   <= caseMem[base+3][0];
        redirect   <= caseMem[base+4][0];
        redirectPc <= caseMem[base+5];
        caseStall  <= caseMem[base+6][4:0];
        pcNext     <= $urandom & 32'hffff_fffc;  // keep word aligned
        r = randomBits();
        fetchIn <= r[FW-1:0];
        r = randomBits();
        decodeIn <= r[DW-1:0];
        r = randomBits();
        renameIn <= r[RW-1:0];
        r = randomBits();
        issueIn <= r[ISSUE_W-1:0];
        r = randomBits();
        execIn <= r[CW-1:0];
    endtask

    // runs at the edge before the new case lands
    task automatic advanceModel();
        logic sF;
        logic sD;
        logic sR;
        logic sI;
        logic sE;
        logic fD;
        logic fR;
        logic fI;
        logic fE;
        logic fC;
        sF = caseStall[4];
        sD = caseStall[3];
        sR = caseStall[2];
        sI = caseStall[1];
        sE = caseStall[0];
        fD = redirect | (sF & ~sD);
        fR = redirect | (sD & ~sR);
        fI = redirect | (sR & ~sI);
        fE = redirect | (sI & ~sE);
        fC = sE;                    // commit squashes while execute holds
        if (redirect) begin
            mPc = redirectPc;
        end else if (!sF) begin
            mPc = pcNext;
        end
        if (fD) begin
            mFetch = '0;
        end else if (!sD) begin
            mFetch = fetchIn;
        end
        if (fR) begin
            mDecode = '0;
        end else if (!sR) begin
            mDecode = decodeIn;
        end
        if (fI) begin
            mRename = '0;
        end else if (!sI) begin
            mRename = renameIn;
        end
        if (fE) begin
            mIssue = '0;
        end else if (!sE) begin
            mIssue = issueIn;
        end
        if (fC) begin
            mCommit = mCommit & ~ctrlMask;  // results survive
        end else begin
            mCommit = execIn;
        end
    endtask

    task automatic checkReset();
        if (pc !== RESET_PC) begin
            flagWrong("pc", 256'(RESET_PC), 256'(pc));
        end
        if (fetchOut !== '0) begin
            flagWrong("fetchOut", '0, 256'(fetchOut));
        end
        if (decodeOut !== '0) begin
            flagWrong("decodeOut", '0, 256'(decodeOut));
        end
        if (renameOut !== '0) begin
            flagWrong("renameOut", '0, 256'(renameOut));
        end
        if (issueOut !== '0) begin
            flagWrong("issueOut", '0, 256'(issueOut));
        end
        if ((commitOut & ctrlMask) !== '0) begin
            flagWrong("commitOut valid/robAddr", '0, 256'(commitOut & ctrlMask));
        end
    endtask

    task automatic compareOutputs();
        if (pc !== mPc) begin
            flagWrong("pc", 256'(mPc), 256'(pc));
        end
        if (fetchOut !== mFetch) begin
            flagWrong("fetchOut", 256'(mFetch), 256'(fetchOut));
        end
        if (decodeOut !== mDecode) begin
            flagWrong("decodeOut", 256'(mDecode), 256'(decodeOut));
        end
        if (renameOut !== mRename) begin
            flagWrong("renameOut", 256'(mRename), 256'(renameOut));
        end
        if (issueOut !== mIssue) begin
            flagWrong("issueOut", 256'(mIssue), 256'(issueOut));
        end
        if (commitOut !== mCommit) begin
            flagWrong("commitOut", 256'(mCommit), 256'(commitOut));
        end
    endtask

    // hang guard
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        errorCount = 0;
        void'($urandom(SEED));
        fetchWait  <= 1'b0;
        renameFull <= 1'b0;
        issueFull  <= 1'b0;
        execBusy   <= 1'b0;
        redirect   <= 1'b0;
        redirectPc <= '0;
        pcNext     <= RESET_PC + PC_STEP;
        fetchIn    <= '0;
        decodeIn   <= '0;
        renameIn   <= '0;
        issueIn    <= '0;
        execIn     <= '0;
        caseStall  <= '0;

        ctrlMask = '0;
        for (int l = 0; l < UNIT_NUM; l++) begin
            ctrlMask[l*COMMIT_LANE_W + LANE_VALID_BIT] = 1'b1;
            ctrlMask[l*COMMIT_LANE_W + LANE_ROB_LSB +: ROB_W] = '1;
        end

        for (int n = 0; n < NUM_CASES*CASE_COLS; n++) begin
            caseMem[n] = '1;        // sentinel for a short file
        end
        $readmemh("verification/spine_cases.txt", caseMem);

        if (caseMem[NUM_CASES*CASE_COLS-1] == 32'hffff_ffff) begin
            $display("case file verification/spine_cases.txt is missing or too short");
            $display("Done: errors found");
            $finish;
        end else begin
            @(posedge resetn);
            @(negedge clk);
            checkReset();
            mPc          = RESET_PC;
            mFetch       = '0;
            mDecode      = '0;
            mRename      = '0;
            mIssue       = '0;
            mCommit      = '0;

            // one extra pass so the last case reaches the outputs
            for (int i = 0; i <= NUM_CASES; i++) begin
                @(posedge clk);
                advanceModel();
                if (i < NUM_CASES) begin
                    applyCase(i);
                end
                @(negedge clk);
                compareOutputs();
            end

            $display("errors: %0d", errorCount);
            if (errorCount == 0) begin
                $display("Done: no errors");
            end else begin
                $display("Done: errors found");
            end
            $finish;
        end
    end

endmodule

// File: verification/clockGen.sv
`timescale 1ns/1ps

module clockGen (
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;      // 8 ns period
    end

    initial begin
        resetn = 1'b0;
        repeat (8) @(posedge clk);  // 8 cycles in reset
        resetn <= 1'b1;
    end

endmodule

// File: hdl/pipeSpine.sv
`timescale 1ns/1ps

module pipeSpine (
    input  logic clk,
    input  logic resetn,

    // stall causes from the stage logic
    input  logic fetchWait,
    input  logic renameFull,
    input  logic issueFull,
    input  logic execBusy,

    // commit-time redirect and predicted fetch address
    input  logic        redirect,
    input  logic [31:0] redirectPc,
    input  logic [31:0] pcNext,

    input  logic [spine_pkg::FETCH_W*spine_pkg::MACHINE_WIDTH-1:0]  fetchIn,
    input  logic [spine_pkg::DECODE_W*spine_pkg::MACHINE_WIDTH-1:0] decodeIn,
    input  logic [spine_pkg::RENAME_W*spine_pkg::MACHINE_WIDTH-1:0] renameIn,
    input  logic [spine_pkg::ISSUE_W-1:0]                           issueIn,
    input  logic [spine_pkg::UNIT_NUM*spine_pkg::COMMIT_LANE_W-1:0] execIn,

    output logic [31:0]                                             pc,
    output logic [spine_pkg::FETCH_W*spine_pkg::MACHINE_WIDTH-1:0]  fetchOut,
    output logic [spine_pkg::DECODE_W*spine_pkg::MACHINE_WIDTH-1:0] decodeOut,
    output logic [spine_pkg::RENAME_W*spine_pkg::MACHINE_WIDTH-1:0] renameOut,
    output logic [spine_pkg::ISSUE_W-1:0]                           issueOut,
    output logic [spine_pkg::UNIT_NUM*spine_pkg::COMMIT_LANE_W-1:0] commitOut
);
    import spine_pkg::*;

    logic stallF, stallD, stallR, stallI, stallE, stallC;
    logic flushD, flushR, flushI, flushE, flushC;

    hazardUnit hazardUnit_i (
        .fetchWait  (fetchWait),
        .renameFull (renameFull),
        .issueFull  (issueFull),
        .execBusy   (execBusy),
        .redirect   (redirect),
        .stallF     (stallF),
        .stallD     (stallD),
        .stallR     (stallR),
        .stallI     (stallI),
        .stallE     (stallE),
        .stallC     (stallC),
        .flushD     (flushD),
        .flushR     (flushR),
        .flushI     (flushI),
        .flushE     (flushE),
        .flushC     (flushC)
    );

    pcReg pcReg_i (
        .clk        (clk),
        .resetn     (resetn),
        .stall      (stallF),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .pcNext     (pcNext),
        .pc         (pc)
    );

    // fetch to decode
    stageReg #(
        .WIDTH (FETCH_W * MACHINE_WIDTH)
    ) fetchReg_i (
        .clk     (clk),
        .resetn  (resetn),
        .stall   (stallD),
        .flush   (flushD),
        .dataIn  (fetchIn),
        .dataOut (fetchOut)
    );

    // decode to rename
    stageReg #(
        .WIDTH (DECODE_W * MACHINE_WIDTH)
    ) decodeReg_i (
        .clk     (clk),
        .resetn  (resetn),
        .stall   (stallR),
        .flush   (flushR),
        .dataIn  (decodeIn),
        .dataOut (decodeOut)
    );

    // rename to issue
    stageReg #(
        .WIDTH (RENAME_W * MACHINE_WIDTH)
    ) renameReg_i (
        .clk     (clk),
        .resetn  (resetn),
        .stall   (stallI),
        .flush   (flushI),
        .dataIn  (renameIn),
        .dataOut (renameOut)
    );

    // issue to execute
    stageReg #(
        .WIDTH (ISSUE_W)
    ) issueReg_i (
        .clk     (clk),
        .resetn  (resetn),
        .stall   (stallE),
        .flush   (flushE),
        .dataIn  (issueIn),
        .dataOut (issueOut)
    );

    commitReg commitReg_i (
        .clk       (clk),
        .resetn    (resetn),
        .stall     (stallC),
        .flush     (flushC),
        .execIn    (execIn),
        .commitOut (commitOut)
    );

endmodule

// File: hdl/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit (
    input  logic fetchWait,
    input  logic renameFull,
    input  logic issueFull,
    input  logic execBusy,
    input  logic redirect,
    output logic stallF,
    output logic stallD,
    output logic stallR,
    output logic stallI,
    output logic stallE,
    output logic stallC,
    output logic flushD,
    output logic flushR,
    output logic flushI,
    output logic flushE,
    output logic flushC
);

    // back-pressure chain from the oldest stage up
    assign stallC = 1'b0;                   // commit never waits
    assign stallE = execBusy;
    assign stallI = stallE | issueFull;
    assign stallR = stallI | renameFull;
    assign stallD = stallR;
    assign stallF = stallD | fetchWait;

    // a stage that runs while its source holds takes a bubble
    assign flushD = redirect | (stallF & ~stallD);  // fetchWait alone
    assign flushR = redirect | (stallD & ~stallR);
    assign flushI = redirect | (stallR & ~stallI);
    assign flushE = redirect | (stallI & ~stallE);
    assign flushC = stallE & ~stallC;               // redirect stops short of commit

    always_comb begin
        // stalls only grow toward fetch
        assert ((!stallE || stallI) && (!stallI || stallR) &&
                (!stallR || stallD) && (!stallD || stallF))
        else $error("stall chain not monotone: F%b D%b R%b I%b E%b",
                    stallF, stallD, stallR, stallI, stallE);

        // a bubble goes only into a stage that is advancing
        assert (redirect || !(flushD && stallD))
        else $error("flushD with stallD and no redirect");
        assert (redirect || !(flushR && stallR))
        else $error("flushR with stallR and no redirect");
        assert (redirect || !(flushI && stallI))
        else $error("flushI with stallI and no redirect");
        assert (redirect || !(flushE && stallE))
        else $error("flushE with stallE and no redirect");
    end

endmodule

// File: hdl/commitReg.sv
`timescale 1ns/1ps

module commitReg (
    input  logic clk,
    input  logic resetn,
    input  logic stall,
    input  logic flush,
    input  logic [spine_pkg::UNIT_NUM*spine_pkg::COMMIT_LANE_W-1:0] execIn,
    output logic [spine_pkg::UNIT_NUM*spine_pkg::COMMIT_LANE_W-1:0] commitOut
);
    import spine_pkg::*;

    logic [UNIT_NUM-1:0][COMMIT_LANE_W-1:0] lanes;
    logic [UNIT_NUM-1:0]                    laneValid;

    // flush clears only the control fields of each lane
    always_ff @(posedge clk) begin
        if (!resetn || flush) begin
            for (int i = 0; i < UNIT_NUM; i++) begin
                lanes[i][LANE_VALID_BIT]         <= 1'b0;
                lanes[i][LANE_ROB_LSB +: ROB_W]  <= '0;
            end
        end else if (!stall) begin
            lanes <= execIn;
        end
    end

    assign commitOut = lanes;

    always_comb begin
        for (int i = 0; i < UNIT_NUM; i++) begin
            laneValid[i] = lanes[i][LANE_VALID_BIT];
        end
    end

    // nothing may retire in the cycle after a squash
    noValidAfterFlush: assert property (
        @(posedge clk) disable iff (!resetn)
        flush |=> (laneValid == '0)
    ) else $error("commit lane valid after flush: %b", laneValid);

endmodule

// File: hdl/stageReg.sv
`timescale 1ns/1ps

module stageReg #(
    parameter int WIDTH = 32
) (
    input  logic             clk,
    input  logic             resetn,
    input  logic             stall,
    input  logic             flush,
    input  logic [WIDTH-1:0] dataIn,
    output logic [WIDTH-1:0] dataOut
);

    logic [WIDTH-1:0] dataQ;

    always_ff @(posedge clk) begin
        if (!resetn || flush) begin
            dataQ <= '0;      // bubble
        end else if (!stall) begin
            dataQ <= dataIn;
        end
    end

    assign dataOut = dataQ;

    // a held stage must not drift while the hazard unit keeps it stalled
    holdOnStall: assert property (
        @(posedge clk) disable iff (!resetn)
        (stall && !flush) |=> $stable(dataOut)
    ) else $error("stage register changed while stalled");

endmodule

// File: hdl/pcReg.sv
`timescale 1ns/1ps

module pcReg (
    input  logic        clk,
    input  logic        resetn,
    input  logic        stall,
    input  logic        redirect,
    input  logic [31:0] redirectPc,
    input  logic [31:0] pcNext,
    output logic [31:0] pc
);
    import spine_pkg::*;

    logic [31:0] pcLoad;
    logic        pcEn;

    // commit redirect beats both stall and the predictor target
    always_comb begin
        if (redirect) begin
            pcLoad = redirectPc;
            pcEn   = 1'b1;
        end else begin
            pcLoad = pcNext;
            pcEn   = ~stall;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pc <= RESET_PC;
        end else if (pcEn) begin
            pc <= pcLoad;
        end
    end

    // a group is MACHINE_WIDTH instructions of PC_STEP/MACHINE_WIDTH bytes each
    pcAligned: assert property (
        @(posedge clk) disable iff (!resetn)
        (pc % (PC_STEP / MACHINE_WIDTH)) == 0
    ) else $error("pc %h not word aligned", pc);

endmodule

// File: hdl/spine_pkg.sv
package spine_pkg;

    // group shape
    localparam int MACHINE_WIDTH = 2;   // slots per fetch/decode/rename group

    // per-slot payload widths
    localparam int FETCH_W  = 65;       // valid, pc, instr
    localparam int DECODE_W = 80;
    localparam int RENAME_W = 96;
    localparam int ISSUE_W  = 160;      // one bundle with no slots

    // commit lanes ALU, ALU, MEM, BRU, MULT
    localparam int UNIT_NUM = 5;
    localparam int ROB_W    = 6;
    localparam int RESULT_W = 32;

    // lane layout {valid, robAddr, result} from the msb down
    localparam int COMMIT_LANE_W  = 1 + ROB_W + RESULT_W;
    localparam int LANE_VALID_BIT = COMMIT_LANE_W - 1;
    localparam int LANE_ROB_LSB   = RESULT_W;

    // fetch addressing
    localparam logic [31:0] RESET_PC = 32'hbfc00000;  // boot rom
    localparam int PC_STEP = 8;         // bytes per full fetch group

endpackage
